/* logic/csr_exc_state.sv */
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_exc_state
    import csr_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  csr_wsel_t  wsel,
    input  csr_word_u  wr_data,
    input  exc_info_t  exc,
    output exc_regs_t  regs,
    output logic [1:0] plv_out
);

    crmd_t                crmd_q;
    prmd_t                prmd_q;
    logic [`CSR_XLEN-1:0] era_q;
    logic [`CSR_XLEN-1:0] eentry_q;
    logic [`CSR_XLEN-1:0] badv_q;

    // crmd: exception entry, then return, then software write
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_q    <= '0;
            crmd_q.da <= 1'b1;
        end else if (exc.excp_flush) begin
            crmd_q.plv <= 2'b00;
            crmd_q.ie  <= 1'b0;
        end else if (exc.ertn_flush) begin
            crmd_q.plv <= prmd_q.pplv;
            crmd_q.ie  <= prmd_q.pie;
        end else if (wsel.crmd) begin
            crmd_q.plv  <= wr_data.crmd.plv;
            crmd_q.ie   <= wr_data.crmd.ie;
            crmd_q.da   <= wr_data.crmd.da;
            crmd_q.pg   <= wr_data.crmd.pg;
            crmd_q.datf <= wr_data.crmd.datf;
            crmd_q.datm <= wr_data.crmd.datm;
        end
    end

    // prmd saves the state that was live at entry
    always_ff @(posedge clk) begin
        if (reset) begin
            prmd_q <= '0;
        end else if (exc.excp_flush) begin
            prmd_q.pplv <= crmd_q.plv;
            prmd_q.pie  <= crmd_q.ie;
        end else if (wsel.prmd) begin
            prmd_q.pplv <= wr_data.prmd.pplv;
            prmd_q.pie  <= wr_data.prmd.pie;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            era_q <= '0;
        end else if (exc.excp_flush) begin
            era_q <= exc.era;
        end else if (wsel.era) begin
            era_q <= wr_data.raw;
        end
    end

    // software write wins over a faulting address
    always_ff @(posedge clk) begin
        if (reset) begin
            badv_q <= '0;
        end else if (wsel.badv) begin
            badv_q <= wr_data.raw;
        end else if (exc.va_error) begin
            badv_q <= exc.bad_va;
        end
    end

    // entry point is 64-byte aligned
    always_ff @(posedge clk) begin
        if (reset) begin
            eentry_q <= '0;
        end else if (wsel.eentry) begin
            eentry_q <= {wr_data.raw[`CSR_XLEN-1:6], 6'b0};
        end
    end

    // forwarded to fetch in the same cycle
    always_comb begin
        if (exc.excp_flush)
            plv_out = 2'b00;
        else if (exc.ertn_flush)
            plv_out = prmd_q.pplv;
        else if (wsel.crmd)
            plv_out = wr_data.crmd.plv;
        else
            plv_out = crmd_q.plv;
    end

    assign regs.crmd   = crmd_q;
    assign regs.prmd   = prmd_q;
    assign regs.era    = era_q;
    assign regs.eentry = eentry_q;
    assign regs.badv   = badv_q;

endmodule

/* logic/csr_intr_timer.sv */
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_intr_timer
    import csr_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  csr_wsel_t         wsel,
    input  csr_word_u         wr_data,
    input  exc_info_t         exc,
    input  logic [`HWI_W-1:0] interrupt,
    input  logic              crmd_ie,
    output intr_regs_t        regs,
    output logic              has_int
);

    ectl_t                ectl_q;
    estat_t               estat_q;
    tcfg_t                tcfg_q;
    logic [`CSR_XLEN-1:0] tval_q;
    logic [`CSR_XLEN-1:0] tid_q;
    logic                 timer_en;
    logic                 ti_clear;
    logic                 timer_fire;
    logic [`CSR_XLEN-1:0] reload_val;

    assign ti_clear   = wsel.ticlr & wr_data.ticlr.clr;
    // a tcfg write restarts the count instead of firing
    assign timer_fire = timer_en & (tval_q == '0) & ~wsel.tcfg;
    assign reload_val = {tcfg_q.initval, 2'b00};

    always_ff @(posedge clk) begin
        if (reset) begin
            ectl_q <= '0;
        end else if (wsel.ectl) begin
            ectl_q.lie[9:0]   <= wr_data.ectl.lie[9:0];
            ectl_q.lie[12:11] <= wr_data.ectl.lie[12:11];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            estat_q <= '0;
        end else begin
            // hw lines sampled every cycle
            estat_q.is[9:2] <= interrupt;

            if (ti_clear)
                estat_q.is[`TI_BIT] <= 1'b0;
            else if (timer_fire)
                estat_q.is[`TI_BIT] <= 1'b1;

            if (exc.excp_flush) begin
                estat_q.ecode    <= exc.ecode;
                estat_q.esubcode <= exc.esubcode;
            end else if (wsel.estat) begin
                // only the software interrupt bits are writable
                estat_q.is[1:0] <= wr_data.estat.is[1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_q <= '0;
        end else if (wsel.tcfg) begin
            tcfg_q <= wr_data.tcfg;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            timer_en <= 1'b0;
        end else if (wsel.tcfg) begin
            timer_en <= wr_data.tcfg.en;
        end else if (timer_fire) begin
            // one-shot stops here, periodic keeps going
            timer_en <= tcfg_q.periodic;
        end
    end

    // countdown value
    always_ff @(posedge clk) begin
        if (wsel.tcfg) begin
            tval_q <= {wr_data.tcfg.initval, 2'b00};
        end else if (timer_en) begin
            if (tval_q != '0)
                tval_q <= tval_q - 1'b1;
            else if (tcfg_q.periodic)
                tval_q <= reload_val;
            else
                tval_q <= '1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tid_q <= '0;
        end else if (wsel.tid) begin
            tid_q <= wr_data.raw;
        end
    end

    assign has_int = (|(ectl_q.lie & estat_q.is)) & crmd_ie;

    assign regs.ectl  = ectl_q;
    assign regs.estat = estat_q;
    assign regs.tcfg  = tcfg_q;
    assign regs.tval  = tval_q;
    // ticlr is write-only, reads as zero
    assign regs.ticlr = '0;
    assign regs.tid   = tid_q;

endmodule

/* logic/csr_params.svh */
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// widths
`define CSR_ADDR_W  14
`define CSR_XLEN    32
`define HWI_W       8
`define IS_W        13

// csr addresses
`define CSR_CRMD    14'h000
`define CSR_PRMD    14'h001
`define CSR_ECTL    14'h004
`define CSR_ESTAT   14'h005
`define CSR_ERA     14'h006
`define CSR_BADV    14'h007
`define CSR_EENTRY  14'h00c
`define CSR_SAVE0   14'h030
`define CSR_SAVE1   14'h031
`define CSR_SAVE2   14'h032
`define CSR_SAVE3   14'h033
`define CSR_TID     14'h040
`define CSR_TCFG    14'h041
`define CSR_TVAL    14'h042
`define CSR_TICLR   14'h044

// timer interrupt bit in estat.is
`define TI_BIT      11

`endif

/* logic/csr_pkg.sv */
`include "csr_params.svh"

package csr_pkg;

    typedef struct packed {
        logic [22:0] zero;
        logic [1:0]  datm;
        logic [1:0]  datf;
        logic        pg;
        logic        da;
        logic        ie;
        logic [1:0]  plv;
    } crmd_t;

    typedef struct packed {
        logic [28:0] zero;
        logic        pie;
        logic [1:0]  pplv;
    } prmd_t;

    // bit 10 of lie has no source and stays zero
    typedef struct packed {
        logic [18:0]       zero;
        logic [`IS_W-1:0]  lie;
    } ectl_t;

    typedef struct packed {
        logic              zero_31;
        logic [8:0]        esubcode;
        logic [5:0]        ecode;
        logic [2:0]        zero_hi;
        logic [`IS_W-1:0]  is;
    } estat_t;

    typedef struct packed {
        logic [29:0] initval;
        logic        periodic;
        logic        en;
    } tcfg_t;

    typedef struct packed {
        logic [30:0] zero;
        logic        clr;
    } ticlr_t;

    // one write word, decoded per target register
    typedef union packed {
        logic [`CSR_XLEN-1:0] raw;
        crmd_t                crmd;
        prmd_t                prmd;
        ectl_t                ectl;
        estat_t               estat;
        tcfg_t                tcfg;
        ticlr_t               ticlr;
    } csr_word_u;

    typedef struct packed {
        logic       crmd;
        logic       prmd;
        logic       ectl;
        logic       estat;
        logic       era;
        logic       badv;
        logic       eentry;
        logic [3:0] save;
        logic       tid;
        logic       tcfg;
        logic       ticlr;
    } csr_wsel_t;

    typedef struct packed {
        logic                 excp_flush;
        logic                 ertn_flush;
        logic [`CSR_XLEN-1:0] era;
        logic [5:0]           ecode;
        logic [8:0]           esubcode;
        logic                 va_error;
        logic [`CSR_XLEN-1:0] bad_va;
    } exc_info_t;

    typedef struct packed {
        crmd_t                crmd;
        prmd_t                prmd;
        logic [`CSR_XLEN-1:0] era;
        logic [`CSR_XLEN-1:0] eentry;
        logic [`CSR_XLEN-1:0] badv;
    } exc_regs_t;

    typedef struct packed {
        ectl_t                ectl;
        estat_t               estat;
        tcfg_t                tcfg;
        logic [`CSR_XLEN-1:0] tval;
        ticlr_t               ticlr;
        logic [`CSR_XLEN-1:0] tid;
    } intr_regs_t;

endpackage

/* logic/csr_unit.sv */
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_unit
    import csr_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`CSR_ADDR_W-1:0] rd_addr,
    input  logic                   wr_en,
    input  logic [`CSR_ADDR_W-1:0] wr_addr,
    input  csr_word_u              wr_data,
    input  exc_info_t              exc,
    input  logic [`HWI_W-1:0]      interrupt,
    output logic [`CSR_XLEN-1:0]   rd_data,
    output logic                   has_int,
    output logic [1:0]             plv_out,
    output logic [`CSR_XLEN-1:0]   eentry_out,
    output logic [`CSR_XLEN-1:0]   era_out,
    output logic [`CSR_XLEN-1:0]   tid_out
);

    csr_wsel_t            wsel;
    exc_regs_t            exc_regs;
    intr_regs_t           intr_regs;
    logic [`CSR_XLEN-1:0] save_q [4];

    // single address decode, submodules only see strobes
    always_comb begin
        wsel = '0;
        if (wr_en) begin
            case (wr_addr)
                `CSR_CRMD:   wsel.crmd    = 1'b1;
                `CSR_PRMD:   wsel.prmd    = 1'b1;
                `CSR_ECTL:   wsel.ectl    = 1'b1;
                `CSR_ESTAT:  wsel.estat   = 1'b1;
                `CSR_ERA:    wsel.era     = 1'b1;
                `CSR_BADV:   wsel.badv    = 1'b1;
                `CSR_EENTRY: wsel.eentry  = 1'b1;
                `CSR_SAVE0:  wsel.save[0] = 1'b1;
                `CSR_SAVE1:  wsel.save[1] = 1'b1;
                `CSR_SAVE2:  wsel.save[2] = 1'b1;
                `CSR_SAVE3:  wsel.save[3] = 1'b1;
                `CSR_TID:    wsel.tid     = 1'b1;
                `CSR_TCFG:   wsel.tcfg    = 1'b1;
                `CSR_TICLR:  wsel.ticlr   = 1'b1;
                default:     wsel         = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                save_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (wsel.save[i])
                    save_q[i] <= wr_data.raw;
            end
        end
    end

    csr_exc_state csr_exc_state_inst (
        .clk     (clk),
        .reset   (reset),
        .wsel    (wsel),
        .wr_data (wr_data),
        .exc     (exc),
        .regs    (exc_regs),
        .plv_out (plv_out)
    );

    csr_intr_timer csr_intr_timer_inst (
        .clk       (clk),
        .reset     (reset),
        .wsel      (wsel),
        .wr_data   (wr_data),
        .exc       (exc),
        .interrupt (interrupt),
        .crmd_ie   (exc_regs.crmd.ie),
        .regs      (intr_regs),
        .has_int   (has_int)
    );

    // unmapped addresses read zero
    always_comb begin
        case (rd_addr)
            `CSR_CRMD:   rd_data = exc_regs.crmd;
            `CSR_PRMD:   rd_data = exc_regs.prmd;
            `CSR_ECTL:   rd_data = intr_regs.ectl;
            `CSR_ESTAT:  rd_data = intr_regs.estat;
            `CSR_ERA:    rd_data = exc_regs.era;
            `CSR_BADV:   rd_data = exc_regs.badv;
            `CSR_EENTRY: rd_data = exc_regs.eentry;
            `CSR_SAVE0:  rd_data = save_q[0];
            `CSR_SAVE1:  rd_data = save_q[1];
            `CSR_SAVE2:  rd_data = save_q[2];
            `CSR_SAVE3:  rd_data = save_q[3];
            `CSR_TID:    rd_data = intr_regs.tid;
            `CSR_TCFG:   rd_data = intr_regs.tcfg;
            `CSR_TVAL:   rd_data = intr_regs.tval;
            `CSR_TICLR:  rd_data = intr_regs.ticlr;
            default:     rd_data = '0;
        endcase
    end

    assign eentry_out = exc_regs.eentry;
    assign era_out    = exc_regs.era;
    assign tid_out    = intr_regs.tid;

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the csr testbench with verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module csr_tb -o csr_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/csr_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
    exit 1
fi
exit 0

/* verif/csr_assertions.sv */
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_assertions
    import csr_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input exc_info_t  exc,
    input exc_regs_t  exc_regs,
    input intr_regs_t intr_regs,
    input logic       has_int,
    input logic [1:0] plv_out
);

    // interrupts are masked by crmd.ie
    has_int_needs_ie: assert property (@(posedge clk) disable iff (reset)
        has_int |-> exc_regs.crmd.ie)
        else $error("has_int high while CRMD.ie is clear");

    eentry_aligned: assert property (@(posedge clk) disable iff (reset)
        exc_regs.eentry[5:0] == 6'b0)
        else $error("EENTRY low six bits not zero");

    // ti only comes from an expiring count
    ti_on_zero: assert property (@(posedge clk) disable iff (reset)
        $rose(intr_regs.estat.is[`TI_BIT]) |-> $past(intr_regs.tval) == 32'h0)
        else $error("TI set while TVAL was not zero");

    plv_zero_on_entry: assert property (@(posedge clk) disable iff (reset)
        exc.excp_flush |-> plv_out == 2'b00)
        else $error("plv_out not zero during exception entry");

endmodule

bind csr_unit csr_assertions csr_assertions_inst (
    .clk       (clk),
    .reset     (reset),
    .exc       (exc),
    .exc_regs  (exc_regs),
    .intr_regs (intr_regs),
    .has_int   (has_int),
    .plv_out   (plv_out)
);

/* verif/csr_tests.svh */
`ifndef CSR_TESTS_SVH
`define CSR_TESTS_SVH

task automatic test_reset_readback();
    logic [`CSR_ADDR_W-1:0] addrs [7];
    logic [`CSR_XLEN-1:0]   data;
    crmd_t                  c;
    addrs = '{`CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3, `CSR_ERA, `CSR_EENTRY, `CSR_TID};
    c = '0;
    c.da = 1'b1;
    read_check(`CSR_CRMD, c);
    check_value("has_int after reset", has_int, 0);
    check_value("plv_out after reset", plv_out, 0);
    foreach (addrs[i]) begin
        data = $random(seed);
        write_csr(addrs[i], data);
        read_check(addrs[i], (addrs[i] == `CSR_EENTRY) ? {data[31:6], 6'b0} : data);
        if (addrs[i] == `CSR_EENTRY)
            check_value("eentry_out", eentry_out, {data[31:6], 6'b0});
    end
    // last write went to TID
    check_value("tid_out", tid_out, data);
    read_check(14'h3ff, '0);
endtask

task automatic test_exception_entry();
    crmd_t                c;
    logic [`CSR_XLEN-1:0] era_in;
    logic [`CSR_XLEN-1:0] rnd;
    estat_t               st;
    c = '0;
    c.da = 1'b1;
    c.plv = 2'd3;
    c.ie = 1'b1;
    write_csr(`CSR_CRMD, c);
    era_in = $random(seed);
    rnd = $random(seed);
    @(negedge clk);
    exc.excp_flush = 1'b1;
    exc.era = era_in;
    exc.ecode = rnd[5:0];
    exc.esubcode = rnd[14:6];
    #1;
    check_value("plv_out during exception", plv_out, 0);
    @(negedge clk);
    exc = '0;
    c.plv = 2'd0;
    c.ie = 1'b0;
    read_check(`CSR_CRMD, c);
    // pplv 3 and pie 1
    read_check(`CSR_PRMD, 32'h7);
    read_check(`CSR_ERA, era_in);
    check_value("era_out", era_out, era_in);
    read_csr(`CSR_ESTAT, st);
    check_value("ESTAT ecode", st.ecode, rnd[5:0]);
    check_value("ESTAT esubcode", st.esubcode, rnd[14:6]);
    rnd = $random(seed);
    @(negedge clk);
    exc.va_error = 1'b1;
    exc.bad_va = rnd;
    @(negedge clk);
    exc = '0;
    read_check(`CSR_BADV, rnd);
endtask

task automatic test_exception_return();
    prmd_t                p;
    crmd_t                c;
    logic [`CSR_XLEN-1:0] rnd;
    rnd = $random(seed);
    p = '0;
    // pplv nonzero and pie set so the restore differs from the entry state
    p.pplv = (rnd[1:0] == 2'b00) ? 2'd3 : rnd[1:0];
    p.pie = 1'b1;
    write_csr(`CSR_PRMD, p);
    @(negedge clk);
    exc.ertn_flush = 1'b1;
    #1;
    check_value("plv_out during return", plv_out, p.pplv);
    @(negedge clk);
    exc = '0;
    c = '0;
    c.da = 1'b1;
    c.plv = p.pplv;
    c.ie = p.pie;
    read_check(`CSR_CRMD, c);
    c.plv = ~p.pplv;
    c.ie = 1'b0;
    @(negedge clk);
    wr_en = 1'b1;
    wr_addr = `CSR_CRMD;
    wr_data.crmd = c;
    #1;
    check_value("plv_out during CRMD write", plv_out, c.plv);
    @(negedge clk);
    wr_en = 1'b0;
    read_check(`CSR_CRMD, c);
endtask

task automatic test_interrupts();
    logic [`CSR_XLEN-1:0] rnd;
    estat_t               st;
    ectl_t                ec;
    crmd_t                c;
    rnd = $random(seed);
    @(negedge clk);
    interrupt = rnd[7:0];
    read_csr(`CSR_ESTAT, st);
    check_value("ESTAT hw lines", st.is[9:2], rnd[7:0]);
    // software bit 0 and enable bit 0 forced on so has_int can rise
    rnd = $random(seed);
    rnd[0] = 1'b1;
    write_csr(`CSR_ESTAT, rnd);
    st.is[1:0] = rnd[1:0];
    read_check(`CSR_ESTAT, st);
    rnd = $random(seed);
    rnd[0] = 1'b1;
    write_csr(`CSR_ECTL, rnd);
    ec = '0;
    ec.lie = rnd[12:0];
    ec.lie[10] = 1'b0;
    read_check(`CSR_ECTL, ec);
    c = '0;
    c.da = 1'b1;
    c.ie = 1'b1;
    write_csr(`CSR_CRMD, c);
    check_value("has_int with ie set", has_int, |(ec.lie & st.is));
    c.ie = 1'b0;
    write_csr(`CSR_CRMD, c);
    check_value("has_int with ie clear", has_int, 0);
endtask

task automatic test_timer();
    tcfg_t                t;
    crmd_t                c;
    logic [`CSR_XLEN-1:0] prev;
    logic [`CSR_XLEN-1:0] word;
    write_csr(`CSR_ECTL, 32'h1 << `TI_BIT);
    c = '0;
    c.da = 1'b1;
    c.ie = 1'b1;
    write_csr(`CSR_CRMD, c);
    t = '0;
    t.en = 1'b1;
    t.initval = 30'd3;
    write_csr(`CSR_TCFG, t);
    prev = '1;
    repeat (8) begin
        read_csr(`CSR_TVAL, word);
        if (word > prev) begin
            $display("Mismatch at %0t: TVAL rose from %h to %h", $time, prev, word);
            mismatch_count++;
        end
        prev = word;
    end
    wait_for_ti(40);
    check_value("has_int on timer", has_int, 1);
    // one-shot parks at all ones
    read_check(`CSR_TVAL, 32'hffff_ffff);
    write_csr(`CSR_TICLR, 32'h1);
    read_csr(`CSR_ESTAT, word);
    check_value("TI after clear", word[`TI_BIT], 0);
    repeat (20) @(negedge clk);
    read_csr(`CSR_ESTAT, word);
    check_value("TI after one-shot expiry", word[`TI_BIT], 0);
    t.periodic = 1'b1;
    write_csr(`CSR_TCFG, t);
    wait_for_ti(40);
    write_csr(`CSR_TICLR, 32'h1);
    read_csr(`CSR_ESTAT, word);
    check_value("TI after periodic clear", word[`TI_BIT], 0);
    wait_for_ti(40);
endtask

`endif

/* verif/csr_tb.sv */
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_tb
    import csr_pkg::*;
();

    logic                   clk;
    logic                   reset;
    logic [`CSR_ADDR_W-1:0] rd_addr;
    logic                   wr_en;
    logic [`CSR_ADDR_W-1:0] wr_addr;
    csr_word_u              wr_data;
    exc_info_t              exc;
    logic [`HWI_W-1:0]      interrupt;
    logic [`CSR_XLEN-1:0]   rd_data;
    logic                   has_int;
    logic [1:0]             plv_out;
    logic [`CSR_XLEN-1:0]   eentry_out;
    logic [`CSR_XLEN-1:0]   era_out;
    logic [`CSR_XLEN-1:0]   tid_out;
    integer                 seed;
    integer                 mismatch_count;
    integer                 timeout_count;

    csr_unit csr_unit_inst (.*);

    always #4 clk = ~clk;

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            mismatch_count++;
        end
    endtask

    // address driven on the falling edge, data sampled just after
    task automatic read_csr(input logic [`CSR_ADDR_W-1:0] addr,
                            output logic [`CSR_XLEN-1:0] data);
        @(negedge clk);
        rd_addr = addr;
        #1;
        data = rd_data;
    endtask

    task automatic read_check(input logic [`CSR_ADDR_W-1:0] addr,
                              input logic [`CSR_XLEN-1:0] exp);
        logic [`CSR_XLEN-1:0] data;
        read_csr(addr, data);
        check_value($sformatf("CSR 0x%03h", addr), data, exp);
    endtask

    task automatic write_csr(input logic [`CSR_ADDR_W-1:0] addr,
                             input logic [`CSR_XLEN-1:0] data);
        @(negedge clk);
        wr_en = 1'b1;
        wr_addr = addr;
        wr_data.raw = data;
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    task automatic wait_for_ti(input int max_cycles);
        logic [`CSR_XLEN-1:0] word;
        logic                 fired;
        fired = 1'b0;
        for (int i = 0; i < max_cycles && !fired; i++) begin
            read_csr(`CSR_ESTAT, word);
            fired = word[`TI_BIT];
        end
        if (!fired) begin
            $display("Timer interrupt did not set within %0d cycles", max_cycles);
            timeout_count++;
        end
    endtask

`include "csr_tests.svh"

    initial begin
        seed = 39584;
        clk = 1'b0;
        reset = 1'b1;
        rd_addr = '0;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        exc = '0;
        interrupt = '0;
        mismatch_count = 0;
        timeout_count = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        test_reset_readback();
        test_exception_entry();
        test_exception_return();
        test_interrupts();
        test_timer();
        $display("csr_tb done: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+logic
+incdir+verif
logic/csr_pkg.sv
logic/csr_exc_state.sv
logic/csr_intr_timer.sv
logic/csr_unit.sv
verif/csr_assertions.sv
verif/csr_tb.sv
